//--- Makefile
# Verilator build and run for the sample player testbench

VERILATOR ?= verilator
TOP       ?= tb_sample_player
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= All checks passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard *.sv) $(wildcard *.svh) $(FILELIST)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$($(abspath $(SIM_BIN)))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- addr_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface addr_stream_if;
    import sampler_pkg::*;

    logic       valid;
    logic       ready;
    dram_addr_t addr;
    logic       last; // marks the final word of a sample

    modport sender (output valid, output addr, output last, input ready);

    modport receiver (input valid, input addr, input last, output ready);

endinterface

`default_nettype wire

//--- clockdomain_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "sampler_config.svh"

module clockdomain_fifo #(
    parameter int DEPTH = `SAMPLER_FIFO_DEPTH
) (
    input  wire             wr_clk,
    input  wire             wr_rst,
    addr_stream_if.receiver wr,
    input  wire             rd_clk,
    addr_stream_if.sender   rd
);
    import sampler_pkg::*;

    localparam int aw = $clog2(DEPTH);

    dram_addr_t mem_addr [0:DEPTH-1];
    logic       mem_last [0:DEPTH-1];

    logic [aw:0] wr_bin;
    logic [aw:0] wr_gray;
    logic [aw:0] wr_bin_next;
    logic [aw:0] rd_gray_s1;
    logic [aw:0] rd_gray_s2;
    logic        full;
    logic        push;

    logic [1:0]  rd_rst_pipe;
    logic        rd_rst;
    logic [aw:0] rd_bin;
    logic [aw:0] rd_gray;
    logic [aw:0] rd_bin_next;
    logic [aw:0] wr_gray_s1;
    logic [aw:0] wr_gray_s2;
    logic        empty;
    logic        pop;

    // full when the pointers differ only in their top two gray bits
    assign full        = (wr_gray == {~rd_gray_s2[aw:aw-1], rd_gray_s2[aw-2:0]});
    assign push        = wr.valid && !full;
    assign wr.ready    = !full;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem_addr[wr_bin[aw-1:0]] <= wr.addr;
            mem_last[wr_bin[aw-1:0]] <= wr.last;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (push) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        rd_rst_pipe <= {rd_rst_pipe[0], wr_rst};
    end

    assign rd_rst = rd_rst_pipe[1];

    assign empty       = (rd_gray == wr_gray_s2);
    assign pop         = rd.valid && rd.ready;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (pop) begin
                rd_bin  <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end
    end

    assign rd.valid = !empty;
    assign rd.addr  = mem_addr[rd_bin[aw-1:0]];
    assign rd.last  = mem_last[rd_bin[aw-1:0]];

endmodule

`default_nettype wire

//--- dram_read_requester.sv
`timescale 1ns/1ps
`default_nettype none

`include "sampler_config.svh"

module dram_read_requester (
    input  wire                     clk,
    input  wire                     clk_dram_ctrl,
    input  wire                     rst,
    input  wire                     midi_din,
    input  wire                     armed,
    input  sampler_pkg::dram_addr_t addr_starts [0:`SAMPLER_INSTRUMENT_COUNT],
    output logic                    dram_valid,
    input  wire                     dram_ready,
    output sampler_pkg::dram_addr_t dram_addr,
    output logic                    dram_last
);
    import sampler_pkg::*;

    localparam int n_voices = `SAMPLER_INSTRUMENT_COUNT;
    localparam midi_key_t midi_keys [0:n_voices-1] = `SAMPLER_MIDI_KEYS;

    logic                note_valid;
    midi_key_t           key;
    midi_vel_t           velocity;
    logic [n_voices-1:0] voice_valid;
    logic [n_voices-1:0] voice_last;
    dram_addr_t          voice_addr [0:n_voices-1];
    voice_idx_t          grant;

    addr_stream_if fifo_wr ();
    addr_stream_if dram_rd ();

    midi_processor u_midi (
        .clk(clk), .rst(rst), .din(midi_din),
        .note_valid(note_valid), .key(key), .velocity(velocity)
    );

    for (genvar i = 0; i < n_voices; i++) begin : g_voice
        addr_stream_if voice_stream ();

        instrument #(.MIDI_KEY(midi_keys[i])) u_instrument (
            .clk(clk), .rst(rst), .armed(armed),
            .note_valid(note_valid), .key(key), .velocity(velocity),
            .addr_start(addr_starts[i]), .addr_stop(addr_starts[i+1]),
            .stream(voice_stream)
        );

        assign voice_valid[i]     = voice_stream.valid;
        assign voice_addr[i]      = voice_stream.addr;
        assign voice_last[i]      = voice_stream.last;
        assign voice_stream.ready = fifo_wr.ready && (grant == voice_idx_t'(i));
    end

    // pointer waits only while the granted voice is blocked by a full FIFO
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
        end else if (!fifo_wr.valid || fifo_wr.ready) begin
            grant <= (grant == voice_idx_t'(n_voices - 1)) ? '0 : grant + 1'b1;
        end
    end

    assign fifo_wr.valid = voice_valid[grant];
    assign fifo_wr.addr  = voice_addr[grant];
    assign fifo_wr.last  = voice_last[grant];

    clockdomain_fifo #(.DEPTH(`SAMPLER_FIFO_DEPTH)) u_fifo (
        .wr_clk(clk), .wr_rst(rst), .wr(fifo_wr),
        .rd_clk(clk_dram_ctrl), .rd(dram_rd)
    );

    assign dram_valid    = dram_rd.valid;
    assign dram_addr     = dram_rd.addr;
    assign dram_last     = dram_rd.last;
    assign dram_rd.ready = dram_ready;

endmodule

`default_nettype wire

//--- instrument.sv
`timescale 1ns/1ps
`default_nettype none

module instrument #(
    parameter sampler_pkg::midi_key_t MIDI_KEY = 7'd60
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     armed,
    input  wire                     note_valid,
    input  sampler_pkg::midi_key_t  key,
    input  sampler_pkg::midi_vel_t  velocity,
    input  sampler_pkg::dram_addr_t addr_start,
    input  sampler_pkg::dram_addr_t addr_stop,
    addr_stream_if.sender           stream
);
    import sampler_pkg::*;

    voice_state_t state;
    dram_addr_t   addr;
    logic         hit;
    logic         at_end;

    assign hit    = armed && note_valid && (key == MIDI_KEY);
    assign at_end = (addr == addr_stop - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= voice_idle;
        end else if (hit) begin
            // a new note restarts the sample, velocity zero is a release
            if (velocity != '0 && addr_start != addr_stop) begin
                state <= voice_playing;
                addr  <= addr_start;
            end else begin
                state <= voice_idle;
            end
        end else if (state == voice_playing && stream.ready) begin
            if (at_end) begin
                state <= voice_idle;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    assign stream.valid = (state == voice_playing);
    assign stream.addr  = addr;
    assign stream.last  = at_end;

endmodule

`default_nettype wire

//--- midi_processor.sv
`timescale 1ns/1ps
`default_nettype none

`include "sampler_config.svh"

module midi_processor (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    din,
    output logic                   note_valid,
    output sampler_pkg::midi_key_t key,
    output sampler_pkg::midi_vel_t velocity
);
    import sampler_pkg::*;

    localparam int clks_per_bit = `SAMPLER_MIDI_CLKS_PER_BIT;
    localparam int cnt_w = $clog2(2 * clks_per_bit);

    logic [1:0]        din_sync;
    logic              rx_bit;
    midi_rx_state_t    rx_state;
    logic [cnt_w-1:0]  bit_cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        rx_shift;
    logic              stop_ok;
    logic              byte_valid;
    midi_parse_state_t parse_state;
    logic              note_on;

    assign rx_bit = din_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            din_sync <= 2'b11; // line idles high
        end else begin
            din_sync <= {din_sync[0], din};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state   <= rx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            bit_cnt    <= bit_cnt + 1'b1;
            case (rx_state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (!rx_bit) rx_state <= rx_start;
                end
                rx_start: begin
                    if (bit_cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
                        bit_cnt  <= '0;
                        bit_idx  <= '0;
                        rx_state <= rx_bit ? rx_idle : rx_data; // glitch rather than a start bit
                    end
                end
                rx_data: begin
                    if (bit_cnt == cnt_w'(clks_per_bit - 1)) begin
                        bit_cnt  <= '0;
                        rx_shift <= {rx_bit, rx_shift[7:1]}; // lsb first on the wire
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) rx_state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (bit_cnt == cnt_w'(clks_per_bit - 1)) stop_ok <= rx_bit;
                    // finish near the end of the stop bit so the next start is seen on time
                    if (bit_cnt == cnt_w'(clks_per_bit + clks_per_bit / 2 - 2)) begin
                        rx_state   <= rx_idle;
                        byte_valid <= stop_ok;
                    end
                end
                default: rx_state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            parse_state <= wait_status;
            note_valid  <= 1'b0;
        end else begin
            note_valid <= 1'b0;
            if (byte_valid) begin
                if (rx_shift[7]) begin
                    note_on     <= rx_shift[4]; // 0x9n is note-on, 0x8n note-off
                    parse_state <= (rx_shift[7:5] == 3'b100) ? wait_key : wait_status;
                end else begin
                    case (parse_state)
                        wait_key: begin
                            key         <= rx_shift[6:0];
                            parse_state <= wait_vel;
                        end
                        wait_vel: begin
                            velocity    <= note_on ? rx_shift[6:0] : '0;
                            note_valid  <= 1'b1;
                            parse_state <= wait_status;
                        end
                        default: parse_state <= wait_status; // stray data byte
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sample_player_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sampler_config.svh"

module sample_player_top (
    input  wire                     clk,
    input  wire                     clk_dram_ctrl,
    input  wire                     rst,
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  wire  [7:0]              wb_adr,
    input  sampler_pkg::wb_data_t   wb_dat_w,
    output sampler_pkg::wb_data_t   wb_dat_r,
    output logic                    wb_ack,
    input  wire                     midi_din,
    output logic                    dram_valid,
    input  wire                     dram_ready,
    output sampler_pkg::dram_addr_t dram_addr,
    output logic                    dram_last
);
    import sampler_pkg::*;

    dram_addr_t addr_starts [0:`SAMPLER_INSTRUMENT_COUNT]; // entry i+1 ends voice i
    logic       armed;

    sample_table u_table (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .addr_starts(addr_starts), .armed(armed)
    );

    dram_read_requester u_requester (
        .clk(clk), .clk_dram_ctrl(clk_dram_ctrl), .rst(rst),
        .midi_din(midi_din), .armed(armed), .addr_starts(addr_starts),
        .dram_valid(dram_valid), .dram_ready(dram_ready),
        .dram_addr(dram_addr), .dram_last(dram_last)
    );

endmodule

`default_nettype wire

//--- sample_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "sampler_config.svh"

module sample_table (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  wire  [7:0]              wb_adr,
    input  sampler_pkg::wb_data_t   wb_dat_w,
    output sampler_pkg::wb_data_t   wb_dat_r,
    output logic                    wb_ack,
    output sampler_pkg::dram_addr_t addr_starts [0:`SAMPLER_INSTRUMENT_COUNT],
    output logic                    armed
);
    import sampler_pkg::*;

    localparam int idx_w = $clog2(`SAMPLER_INSTRUMENT_COUNT + 2);
    localparam logic [7:0] ctrl_word = 8'(`SAMPLER_INSTRUMENT_COUNT + 1);

    dram_addr_t       starts [0:`SAMPLER_INSTRUMENT_COUNT];
    logic             access;
    logic [idx_w-1:0] idx;

    assign access = wb_cyc && wb_stb && !wb_ack; // one ack per strobe
    assign idx    = wb_adr[idx_w-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            armed  <= 1'b0;
        end else begin
            wb_ack <= access;
            if (access && wb_we && wb_adr == ctrl_word) armed <= wb_dat_w[0];
        end
    end

    always_ff @(posedge clk) begin
        if (access && wb_we && wb_adr < ctrl_word) starts[idx] <= wb_dat_w[$bits(dram_addr_t)-1:0];
        if (access && !wb_we) begin
            if (wb_adr < ctrl_word) wb_dat_r <= wb_data_t'(starts[idx]);
            else if (wb_adr == ctrl_word) wb_dat_r <= wb_data_t'(armed);
            else wb_dat_r <= '0;
        end
    end

    assign addr_starts = starts;

endmodule

`default_nettype wire

//--- sampler_config.svh
`ifndef SAMPLER_CONFIG_SVH
`define SAMPLER_CONFIG_SVH

// number of voices, one per entry of the key list
`define SAMPLER_INSTRUMENT_COUNT 4
`define SAMPLER_MIDI_KEYS '{7'd60, 7'd62, 7'd64, 7'd65}

`define SAMPLER_ADDR_WIDTH 24

// 16 for simulation, 3200 for 31250 baud at 100 MHz
`define SAMPLER_MIDI_CLKS_PER_BIT 16

`define SAMPLER_FIFO_DEPTH 16 // must be a power of two

`endif

//--- sampler_pkg.sv
`default_nettype none

`include "sampler_config.svh"

package sampler_pkg;

    typedef logic [`SAMPLER_ADDR_WIDTH-1:0] dram_addr_t;
    typedef logic [6:0] midi_key_t;
    typedef logic [6:0] midi_vel_t;
    typedef logic [$clog2(`SAMPLER_INSTRUMENT_COUNT)-1:0] voice_idx_t;
    typedef logic [31:0] wb_data_t;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} midi_rx_state_t;

    typedef enum logic [1:0] {wait_status, wait_key, wait_vel} midi_parse_state_t;

    typedef enum logic {voice_idle, voice_playing} voice_state_t;

endpackage

`default_nettype wire

//--- sim.f
+incdir+.
sampler_pkg.sv
addr_stream_if.sv
midi_processor.sv
instrument.sv
clockdomain_fifo.sv
sample_table.sv
dram_read_requester.sv
sample_player_top.sv
tb_sample_player.sv

//--- tb_sample_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "sampler_config.svh"

module tb_sample_player;
    import sampler_pkg::*;

    localparam int n_voices     = `SAMPLER_INSTRUMENT_COUNT;
    localparam int bit_cycles   = `SAMPLER_MIDI_CLKS_PER_BIT;
    localparam int bit_ns       = bit_cycles * 10;
    localparam int quiet_cycles = 120;
    localparam logic [7:0] ctrl_adr = 8'(n_voices + 1);
    localparam midi_key_t voice_keys [0:n_voices-1] = `SAMPLER_MIDI_KEYS;

    // entry i+1 is the stop of voice i, voice 2 is the long one with 52 words
    localparam dram_addr_t table_starts [0:n_voices] =
        '{24'h000100, 24'h000108, 24'h000110, 24'h000144, 24'h000154};

    localparam int n_messages  = 10;
    localparam int n_settles   = 8;
    localparam int n_words     = 196;
    localparam int watchdog_ns = 2 * (n_messages * 32 * bit_ns
                                      + n_settles * quiet_cycles * 10
                                      + n_words * 4 * 14 + 2000);

    localparam int ready_high   = 0;
    localparam int ready_hold   = 1;
    localparam int ready_random = 2;

    logic       clk = 1'b0;
    logic       clk_dram_ctrl = 1'b0;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [7:0] wb_adr;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;
    logic       midi_din;
    logic       dram_valid;
    logic       dram_ready = 1'b0;
    dram_addr_t dram_addr;
    logic       dram_last;

    int         seed = 32'h0c33c424;
    int         ready_mode = ready_hold;
    dram_addr_t got_addr [$];
    logic       got_last [$];

    sample_player_top UUT (
        .clk(clk), .clk_dram_ctrl(clk_dram_ctrl), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .midi_din(midi_din),
        .dram_valid(dram_valid), .dram_ready(dram_ready),
        .dram_addr(dram_addr), .dram_last(dram_last)
    );

    always #5 clk = ~clk;
    always #7 clk_dram_ctrl = ~clk_dram_ctrl; // unrelated to clk on purpose

    always @(negedge clk_dram_ctrl) begin
        case (ready_mode)
            ready_hold:   dram_ready = 1'b0;
            ready_random: dram_ready = ($random(seed) & 3) != 0; // low about one cycle in four
            default:      dram_ready = 1'b1;
        endcase
    end

    always @(posedge clk_dram_ctrl) begin
        if (!rst && dram_valid === 1'b1 && dram_ready === 1'b1) begin
            got_addr.push_back(dram_addr);
            got_last.push_back(dram_last);
        end
    end

    initial begin
        #(watchdog_ns);
        abort_run("watchdog expired before the tests finished");
    end

    task automatic abort_run(input string why);
        if (why != "") $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("");
        end
    endtask

    task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
            abort_run("");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run("");
        end
    endtask

    // one classic cycle, ack must follow the strobe by exactly one clock
    task automatic wb_cycle(input logic we, input logic [7:0] adr, input wb_data_t wdata,
                            output wb_data_t rdata);
        @(negedge clk);
        check_bit("wb_ack", wb_ack, 1'b0);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        check_bit("wb_ack", wb_ack, 1'b1);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        check_bit("wb_ack", wb_ack, 1'b0);
    endtask

    task automatic wb_write(input logic [7:0] adr, input wb_data_t data);
        wb_data_t unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output wb_data_t data);
        wb_cycle(1'b0, adr, '0, data);
    endtask

    task automatic midi_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            midi_din = frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
    endtask

    task automatic midi_send(input logic [7:0] status, input midi_key_t key,
                             input midi_vel_t vel);
        @(negedge clk);
        midi_byte(status);
        midi_byte({1'b0, key});
        midi_byte({1'b0, vel});
        repeat (2 * bit_cycles) @(negedge clk); // idle gap lets the parser finish
    endtask

    task automatic wait_for_words(input int n);
        int cycles;
        cycles = 0;
        while (got_addr.size() < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > n * 8 + 400)
                abort_run($sformatf("timed out waiting for %0d DRAM words, got %0d",
                                    n, got_addr.size()));
        end
    endtask

    task automatic settle();
        repeat (quiet_cycles) @(negedge clk);
    endtask

    task automatic clear_words();
        got_addr.delete();
        got_last.delete();
    endtask

    // walks the words of one voice in order and expects last only on the final one
    task automatic check_voice(input int v, output int n);
        dram_addr_t first;
        dram_addr_t stop;
        first = table_starts[v];
        stop  = table_starts[v+1];
        n     = 0;
        foreach (got_addr[i]) begin
            if (got_addr[i] >= first && got_addr[i] < stop) begin
                check_addr("dram_addr", got_addr[i], first + dram_addr_t'(n));
                check_bit("dram_last", got_last[i], n == voice_len(v) - 1);
                n++;
            end
        end
    endtask

    function automatic int voice_len(input int v);
        return int'(table_starts[v+1] - table_starts[v]);
    endfunction

    task automatic test_table();
        wb_data_t rdata;
        wb_read(ctrl_adr, rdata);
        check_word("wb_dat_r arm", rdata, 32'h0); // arm is clear after reset
        for (int i = 0; i <= n_voices; i++)
            wb_write(8'(i), wb_data_t'(table_starts[i]) | 32'hA5000000); // upper bits dropped
        wb_write(ctrl_adr, 32'h1);
        for (int i = 0; i <= n_voices; i++) begin
            wb_read(8'(i), rdata);
            check_word($sformatf("wb_dat_r[%0d]", i), rdata, wb_data_t'(table_starts[i]));
        end
        wb_read(ctrl_adr, rdata);
        check_word("wb_dat_r arm", rdata, 32'h1);
        wb_write(ctrl_adr, 32'h0);
        wb_read(ctrl_adr, rdata);
        check_word("wb_dat_r arm", rdata, 32'h0);
    endtask

    task automatic test_arm_and_play();
        int n;
        clear_words();
        ready_mode = ready_high;
        midi_send(8'h90, voice_keys[0], 7'd100);
        settle();
        check_count("words before arm", got_addr.size(), 0);
        wb_write(ctrl_adr, 32'h1);
        midi_send(8'h90, voice_keys[0], 7'd100);
        wait_for_words(voice_len(0));
        settle();
        check_count("words total", got_addr.size(), voice_len(0));
        check_voice(0, n);
        check_count("voice 0 words", n, voice_len(0));
    endtask

    task automatic test_two_voices();
        int n;
        clear_words();
        ready_mode = ready_hold; // both voices queue up behind a full FIFO
        midi_send(8'h90, voice_keys[2], 7'd90);
        midi_send(8'h90, voice_keys[3], 7'd90);
        ready_mode = ready_high;
        wait_for_words(voice_len(2) + voice_len(3));
        settle();
        check_count("words total", got_addr.size(), voice_len(2) + voice_len(3));
        check_voice(2, n);
        check_count("voice 2 words", n, voice_len(2));
        check_voice(3, n);
        check_count("voice 3 words", n, voice_len(3));
    endtask

    task automatic test_backpressure();
        int n;
        clear_words();
        ready_mode = ready_random;
        midi_send(8'h90, voice_keys[2], 7'd64);
        wait_for_words(voice_len(2));
        settle();
        ready_mode = ready_high;
        check_count("words total", got_addr.size(), voice_len(2));
        check_voice(2, n);
        check_count("voice 2 words", n, voice_len(2));
    endtask

    task automatic test_note_off();
        int n;
        int seen;
        clear_words();
        ready_mode = ready_hold;
        midi_send(8'h90, voice_keys[2], 7'd100);
        midi_send(8'h80, voice_keys[2], 7'd64);
        ready_mode = ready_high;
        settle();
        seen = got_addr.size();
        check_voice(2, n);
        check_count("words total", seen, n);
        if (n == 0 || n >= voice_len(2))
            abort_run($sformatf("note-off left %0d words instead of a partial sample", n));
        settle();
        check_count("words after note-off", got_addr.size(), seen);
        clear_words();
        midi_send(8'h90, voice_keys[2], 7'd100);
        wait_for_words(voice_len(2));
        settle();
        check_voice(2, n);
        check_count("voice 2 words after restart", n, voice_len(2));
    endtask

    task automatic test_ignored_notes();
        clear_words();
        midi_send(8'h90, 7'd61, 7'd100); // 61 is between the mapped keys
        midi_send(8'h90, voice_keys[1], 7'd0);
        settle();
        check_count("words from ignored notes", got_addr.size(), 0);
    endtask

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        midi_din = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_bit("wb_ack", wb_ack, 1'b0);
        check_bit("dram_valid", dram_valid, 1'b0);

        test_table();
        test_arm_and_play();
        test_two_voices();
        test_backpressure();
        test_note_off();
        test_ignored_notes();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
